// File: include/fpu_mul_defines.svh
`ifndef FPU_MUL_DEFINES_SVH
`define FPU_MUL_DEFINES_SVH

// internal exponent path, carry and sign on top of 11 bits
`define FPU_MUL_EXPW      13

// exponent biases
`define FPU_MUL_DBL_BIAS  1023
`define FPU_MUL_SGL_BIAS  127

// all-ones exponents, inf and nan
`define FPU_MUL_DBL_EMAX  2047
`define FPU_MUL_SGL_EMAX  255

// stepped stages from input capture (m1) to the output register
`define FPU_MUL_DEPTH     5

`endif

// File: design/fpu_mul_pkg.sv
`default_nettype none

package fpu_mul_pkg;

	typedef enum logic {
		OP_FMULS = 1'b0, // single precision multiply
		OP_FMULD = 1'b1  // double precision multiply
	} fpu_op_e;

	typedef struct packed {
		logic        sign;
		logic [10:0] exp;
		logic [51:0] frac;
	} fpu_dbl_s;

	// single sits in the low half of the word
	typedef struct packed {
		logic [31:0] unused; // upper half, ignored
		logic        sign;
		logic [7:0]  exp;
		logic [22:0] frac;
	} fpu_sgl_s;

	// one operand word, two views
	typedef union packed {
		fpu_dbl_s dbl;
		fpu_sgl_s sgl;
	} fpu_operand_u;

	typedef enum logic [1:0] {
		CLS_ZERO = 2'd0, // zero or subnormal
		CLS_NORM = 2'd1,
		CLS_INF  = 2'd2,
		CLS_NAN  = 2'd3
	} fpu_class_e;

endpackage

`default_nettype wire

// File: design/fpu_mul_ctl.sv
`timescale 1ns/10ps
`default_nettype none
`include "fpu_mul_defines.svh"

module fpu_mul_ctl (
	input  wire                       i_rclk,
	input  wire                       i_reset,
	input  wire                       i_valid,
	input  wire fpu_mul_pkg::fpu_op_e i_op,
	input  wire fpu_mul_pkg::fpu_operand_u i_in1,
	input  wire fpu_mul_pkg::fpu_operand_u i_in2,
	input  wire                       i_hold,
	output logic                      o_step,
	output logic                      o_m1_dbl,
	output logic                      o_m1_sgl,
	output logic                      o_m2_sel_add,
	output logic                      o_m2_sel_max,
	output logic                      o_m2_nan,
	output logic                      o_m2_zero_frac,
	output logic                      o_m2_sign,
	output logic                      o_m5_fmuld,
	output logic                      o_m5_valid,
	output logic                      o_valid
);

	localparam int DEPTH = `FPU_MUL_DEPTH;

	logic                     in_dbl;                 // input is fmuld
	fpu_mul_pkg::fpu_class_e  in1_cls, in2_cls;       // input classes
	logic                     in_sign;                // product sign
	fpu_mul_pkg::fpu_class_e  m1_cls1, m1_cls2;
	logic                     m1_sign;
	logic [DEPTH-1:0]         stg_valid;              // [0]=m1 .. [4]=m5
	logic [DEPTH-1:0]         stg_dbl;                // op code along the pipe
	logic                     m1_any_nan, m1_any_inf, m1_any_zero;
	logic                     m1_nan, m1_inf, m1_zero;

	// operand class from the view picked by the op code
	function automatic fpu_mul_pkg::fpu_class_e classify(
		input fpu_mul_pkg::fpu_operand_u word,
		input logic                      dbl
	);
		logic exp_zero;
		logic exp_max;
		logic frac_zero;
		if (dbl) begin
			exp_zero  = (word.dbl.exp == 11'd0);
			exp_max   = (word.dbl.exp == 11'(`FPU_MUL_DBL_EMAX));
			frac_zero = (word.dbl.frac == 52'd0);
		end else begin
			exp_zero  = (word.sgl.exp == 8'd0);
			exp_max   = (word.sgl.exp == 8'(`FPU_MUL_SGL_EMAX));
			frac_zero = (word.sgl.frac == 23'd0);
		end
		if (exp_zero)
			return fpu_mul_pkg::CLS_ZERO; // subnormals read as zero
		else if (exp_max && frac_zero)
			return fpu_mul_pkg::CLS_INF;
		else if (exp_max)
			return fpu_mul_pkg::CLS_NAN;
		else
			return fpu_mul_pkg::CLS_NORM;
	endfunction

	assign o_step = !i_hold; // whole pipe moves together

	assign in_dbl  = (i_op == fpu_mul_pkg::OP_FMULD);
	assign in1_cls = classify(i_in1, in_dbl);
	assign in2_cls = classify(i_in2, in_dbl);
	assign in_sign = in_dbl ? (i_in1.dbl.sign ^ i_in2.dbl.sign)
	                        : (i_in1.sgl.sign ^ i_in2.sgl.sign);

	//////////////////////////////////////////////////
	// stage valids and op code, m1 to m5
	//////////////////////////////////////////////////

	always_ff @(posedge i_rclk) begin
		if (i_reset) begin
			stg_valid <= '0;
			stg_dbl   <= '0;
			o_valid   <= 1'b0;
		end else if (o_step) begin
			stg_valid <= {stg_valid[DEPTH-2:0], i_valid};
			stg_dbl   <= {stg_dbl[DEPTH-2:0], in_dbl};
			o_valid   <= stg_valid[DEPTH-1]; // lines up with the result register
		end
	end

	// classes and sign into m1
	always_ff @(posedge i_rclk) begin
		if (o_step) begin
			m1_cls1 <= in1_cls;
			m1_cls2 <= in2_cls;
			m1_sign <= in_sign;
		end
	end

	assign o_m1_dbl   = stg_dbl[0];
	assign o_m1_sgl   = !stg_dbl[0];
	assign o_m5_fmuld = stg_dbl[DEPTH-1];
	assign o_m5_valid = stg_valid[DEPTH-1];

	//////////////////////////////////////////////////
	// special result decode, m1
	//////////////////////////////////////////////////

	assign m1_any_nan  = (m1_cls1 == fpu_mul_pkg::CLS_NAN)  || (m1_cls2 == fpu_mul_pkg::CLS_NAN);
	assign m1_any_inf  = (m1_cls1 == fpu_mul_pkg::CLS_INF)  || (m1_cls2 == fpu_mul_pkg::CLS_INF);
	assign m1_any_zero = (m1_cls1 == fpu_mul_pkg::CLS_ZERO) || (m1_cls2 == fpu_mul_pkg::CLS_ZERO);

	assign m1_nan  = m1_any_nan || (m1_any_inf && m1_any_zero); // inf * 0 is invalid
	assign m1_inf  = m1_any_inf && !m1_nan;
	assign m1_zero = m1_any_zero && !m1_nan;

	// select strobes for m2
	always_ff @(posedge i_rclk) begin
		if (i_reset) begin
			o_m2_sel_add   <= 1'b0;
			o_m2_sel_max   <= 1'b0;
			o_m2_nan       <= 1'b0;
			o_m2_zero_frac <= 1'b0;
		end else if (o_step) begin
			o_m2_sel_add   <= !(m1_nan || m1_inf || m1_zero); // plain arithmetic
			o_m2_sel_max   <= m1_nan || m1_inf;               // all-ones exponent
			o_m2_nan       <= m1_nan;
			o_m2_zero_frac <= m1_inf || m1_zero;
		end
	end

	always_ff @(posedge i_rclk) begin
		if (o_step)
			o_m2_sign <= m1_sign;
	end

endmodule

`default_nettype wire

// File: design/fpu_mul_exp_dp.sv
`timescale 1ns/10ps
`default_nettype none
`include "fpu_mul_defines.svh"

module fpu_mul_exp_dp (
	input  wire        i_rclk,
	input  wire        i_reset,
	input  wire        i_step,
	input  wire [10:0] i_in1_exp,
	input  wire [10:0] i_in2_exp,
	input  wire        i_m1_dbl,
	input  wire        i_m1_sgl,
	input  wire        i_m2_sel_add,
	input  wire        i_m2_sel_max,
	input  wire        i_m4_norm_shift,
	input  wire        i_m5_round_cout,
	input  wire        i_m5_fmuld,
	output logic [10:0] o_m5_exp_out,
	output logic        o_m5_of,
	output logic        o_m5_uf
);

	localparam int EW = `FPU_MUL_EXPW;

	localparam logic [EW-1:0] DBL_BIAS = `FPU_MUL_DBL_BIAS;
	localparam logic [EW-1:0] SGL_BIAS = `FPU_MUL_SGL_BIAS;
	localparam logic [EW-1:0] DBL_EMAX = `FPU_MUL_DBL_EMAX;
	localparam logic [EW-1:0] SGL_EMAX = `FPU_MUL_SGL_EMAX;

	logic [10:0]   m1_exp1, m1_exp2;
	logic [EW-1:0] m1_add_in1, m1_add_in2;
	logic [EW-1:0] m1_expadd;     // raw biased sum
	logic [EW-1:0] m2_exp;
	logic          m2_dbl;        // format for the bias
	logic [EW-1:0] m2_unbiased;
	logic [EW-1:0] m2_exp_sel;
	logic [EW-1:0] m3_exp;
	logic [EW-1:0] m4_exp;
	logic [EW-1:0] m4_exp_inc;
	logic [EW-1:0] m5_exp;
	logic [EW-1:0] m5_exp_rnd;    // after the rounding carry
	logic [EW-1:0] m5_emax;

	//////////////////////////////////////////////////
	// m1: capture and add
	//////////////////////////////////////////////////

	always_ff @(posedge i_rclk) begin
		if (i_step) begin
			m1_exp1 <= i_in1_exp;
			m1_exp2 <= i_in2_exp;
		end
	end

	// width select, single exponent lives in [7:0]
	assign m1_add_in1 = ({EW{i_m1_dbl}} & {2'b00, m1_exp1})
	                  | ({EW{i_m1_sgl}} & {5'b00000, m1_exp1[7:0]});
	assign m1_add_in2 = ({EW{i_m1_dbl}} & {2'b00, m1_exp2})
	                  | ({EW{i_m1_sgl}} & {5'b00000, m1_exp2[7:0]});
	assign m1_expadd  = m1_add_in1 + m1_add_in2;

	always_ff @(posedge i_rclk) begin
		if (i_reset)
			m2_dbl <= 1'b0;
		else if (i_step)
			m2_dbl <= i_m1_dbl;
	end

	always_ff @(posedge i_rclk) begin
		if (i_step)
			m2_exp <= m1_expadd;
	end

	//////////////////////////////////////////////////
	// m2: remove bias or force a constant
	//////////////////////////////////////////////////

	assign m2_unbiased = m2_exp - (m2_dbl ? DBL_BIAS : SGL_BIAS); // may go negative
	assign m2_exp_sel  = ({EW{i_m2_sel_add}} & m2_unbiased)
	                   | ({EW{i_m2_sel_max}} & (m2_dbl ? DBL_EMAX : SGL_EMAX)); // zero when idle

	// m3 and m4 just carry the exponent past the multiplier
	always_ff @(posedge i_rclk) begin
		if (i_step) begin
			m3_exp <= m2_exp_sel;
			m4_exp <= m3_exp;
		end
	end

	//////////////////////////////////////////////////
	// m4: normalize increment
	//////////////////////////////////////////////////

	assign m4_exp_inc = m4_exp + {{(EW-1){1'b0}}, i_m4_norm_shift}; // product was >= 2

	always_ff @(posedge i_rclk) begin
		if (i_step)
			m5_exp <= m4_exp_inc;
	end

	//////////////////////////////////////////////////
	// m5: rounding carry, range check
	//////////////////////////////////////////////////

	assign m5_exp_rnd = m5_exp + {{(EW-1){1'b0}}, i_m5_round_cout};
	assign m5_emax    = i_m5_fmuld ? DBL_EMAX : SGL_EMAX;

	assign o_m5_of = !m5_exp_rnd[EW-1] && (m5_exp_rnd >= m5_emax); // inf and nan land here too
	assign o_m5_uf = m5_exp_rnd[EW-1] || (m5_exp_rnd == '0);       // zero or below

	always_comb begin
		if (o_m5_of)
			o_m5_exp_out = m5_emax[10:0];
		else if (o_m5_uf)
			o_m5_exp_out = 11'd0; // flush
		else
			o_m5_exp_out = m5_exp_rnd[10:0];
	end

endmodule

`default_nettype wire

// File: design/fpu_mul_frac_dp.sv
`timescale 1ns/10ps
`default_nettype none
`include "fpu_mul_defines.svh"

module fpu_mul_frac_dp (
	input  wire                       i_rclk,
	input  wire                       i_reset,
	input  wire                       i_step,
	input  wire [51:0]                i_in1_frac,
	input  wire [51:0]                i_in2_frac,
	input  wire fpu_mul_pkg::fpu_op_e i_op,
	input  wire                       i_m2_nan,
	input  wire                       i_m2_zero_frac,
	input  wire                       i_m2_sign,
	input  wire [10:0]                i_m5_exp_out,
	input  wire                       i_m5_of,
	input  wire                       i_m5_uf,
	input  wire                       i_m5_valid,
	output logic                      o_m4_norm_shift,
	output logic                      o_m5_round_cout,
	output logic [63:0]               o_result
);

	localparam int DEPTH = `FPU_MUL_DEPTH;

	logic [DEPTH-1:0] stg_dbl;            // [0]=m1 .. [4]=m5
	logic [51:0]      m1_frac1, m1_frac2;
	logic [52:0]      m1_sig1, m1_sig2;   // hidden one, left aligned
	logic [52:0]      m2_sig1, m2_sig2;
	logic             m2_clear;
	logic [52:0]      m3_sig1, m3_sig2;
	logic             m3_nan, m3_sign;
	logic [105:0]     m4_prod;
	logic             m4_nan, m4_sign;
	logic [105:0]     m4_norm;            // leading one at 105
	logic [52:0]      m4_mant;
	logic             m4_guard, m4_sticky;
	logic [52:0]      m5_mant;
	logic             m5_guard, m5_sticky, m5_nan, m5_sign;
	logic             m5_lsb;
	logic             m5_round_up;
	logic [53:0]      m5_sum;
	logic [52:0]      m5_sig;
	fpu_mul_pkg::fpu_operand_u m5_pack;

	always_ff @(posedge i_rclk) begin
		if (i_reset)
			stg_dbl <= '0;
		else if (i_step)
			stg_dbl <= {stg_dbl[DEPTH-2:0], (i_op == fpu_mul_pkg::OP_FMULD)};
	end

	//////////////////////////////////////////////////
	// m1, m2: significands
	//////////////////////////////////////////////////

	always_ff @(posedge i_rclk) begin
		if (i_step) begin
			m1_frac1 <= i_in1_frac;
			m1_frac2 <= i_in2_frac;
		end
	end

	// single padded below so both formats normalize at the same bits
	assign m1_sig1 = stg_dbl[0] ? {1'b1, m1_frac1} : {1'b1, m1_frac1[22:0], 29'd0};
	assign m1_sig2 = stg_dbl[0] ? {1'b1, m1_frac2} : {1'b1, m1_frac2[22:0], 29'd0};

	assign m2_clear = i_m2_zero_frac || i_m2_nan; // zero, inf and nan carry no product

	always_ff @(posedge i_rclk) begin
		if (i_step) begin
			m2_sig1 <= m1_sig1;
			m2_sig2 <= m1_sig2;
			m3_sig1 <= m2_clear ? 53'd0 : m2_sig1;
			m3_sig2 <= m2_clear ? 53'd0 : m2_sig2;
			m3_nan  <= i_m2_nan;
			m3_sign <= i_m2_sign;
		end
	end

	//////////////////////////////////////////////////
	// m3: multiply, m4: normalize
	//////////////////////////////////////////////////

	always_ff @(posedge i_rclk) begin
		if (i_step) begin
			m4_prod <= m3_sig1 * m3_sig2; // 53 x 53
			m4_nan  <= m3_nan;
			m4_sign <= m3_sign;
		end
	end

	assign o_m4_norm_shift = m4_prod[105]; // product in [2,4)
	assign m4_norm = o_m4_norm_shift ? m4_prod : {m4_prod[104:0], 1'b0};

	always_comb begin
		if (stg_dbl[3]) begin
			m4_mant   = m4_norm[105:53];
			m4_guard  = m4_norm[52];
			m4_sticky = |m4_norm[51:0];
		end else begin
			m4_mant   = {m4_norm[105:82], 29'd0}; // 24 bits kept
			m4_guard  = m4_norm[81];
			m4_sticky = |m4_norm[80:0];
		end
	end

	always_ff @(posedge i_rclk) begin
		if (i_step) begin
			m5_mant   <= m4_mant;
			m5_guard  <= m4_guard;
			m5_sticky <= m4_sticky;
			m5_nan    <= m4_nan;
			m5_sign   <= m4_sign;
		end
	end

	//////////////////////////////////////////////////
	// m5: round to nearest even, pack
	//////////////////////////////////////////////////

	assign m5_lsb      = stg_dbl[4] ? m5_mant[0] : m5_mant[29];
	assign m5_round_up = m5_guard && (m5_sticky || m5_lsb); // ties go to even
	assign m5_sum      = {1'b0, m5_mant}
	                   + (m5_round_up ? (stg_dbl[4] ? 54'd1 : (54'd1 << 29)) : 54'd0);

	assign o_m5_round_cout = m5_sum[53];
	assign m5_sig = o_m5_round_cout ? m5_sum[53:1] : m5_sum[52:0]; // shift right on carry

	always_comb begin
		m5_pack = '0; // upper half stays zero for singles
		if (stg_dbl[4]) begin
			m5_pack.dbl.sign = m5_sign && !m5_nan; // canonical nan is positive
			m5_pack.dbl.exp  = i_m5_exp_out;
			if (m5_nan)
				m5_pack.dbl.frac = {1'b1, 51'd0}; // quiet bit only
			else if (!i_m5_of && !i_m5_uf)
				m5_pack.dbl.frac = m5_sig[51:0];
		end else begin
			m5_pack.sgl.sign = m5_sign && !m5_nan;
			m5_pack.sgl.exp  = i_m5_exp_out[7:0];
			if (m5_nan)
				m5_pack.sgl.frac = {1'b1, 22'd0};
			else if (!i_m5_of && !i_m5_uf)
				m5_pack.sgl.frac = m5_sig[51:29];
		end
	end

	// result register, loads valid ops only
	always_ff @(posedge i_rclk) begin
		if (i_reset)
			o_result <= '0;
		else if (i_step && i_m5_valid)
			o_result <= m5_pack;
	end

endmodule

`default_nettype wire

// File: design/fpu_mul.sv
`timescale 1ns/10ps
`default_nettype none

module fpu_mul (
	input  wire                            i_rclk,
	input  wire                            i_reset,
	input  wire                            i_valid,
	input  wire fpu_mul_pkg::fpu_op_e      i_op,
	input  wire fpu_mul_pkg::fpu_operand_u i_in1,
	input  wire fpu_mul_pkg::fpu_operand_u i_in2,
	input  wire                            i_hold,
	output wire                            o_valid,
	output wire [63:0]                     o_result
);

	wire        m_step;                  // pipe advance
	wire        m1_dbl, m1_sgl;
	wire        m2_sel_add, m2_sel_max;
	wire        m2_nan, m2_zero_frac, m2_sign;
	wire        m5_fmuld, m5_valid;
	wire        m4_norm_shift, m5_round_cout;
	wire [10:0] m5_exp_out;
	wire        m5_of, m5_uf;
	wire [10:0] in1_exp, in2_exp;        // exponent field of either view

	assign in1_exp = (i_op == fpu_mul_pkg::OP_FMULD) ? i_in1.dbl.exp : {3'b000, i_in1.sgl.exp};
	assign in2_exp = (i_op == fpu_mul_pkg::OP_FMULD) ? i_in2.dbl.exp : {3'b000, i_in2.sgl.exp};

	fpu_mul_ctl u_ctl (
		.i_rclk         (i_rclk),
		.i_reset        (i_reset),
		.i_valid        (i_valid),
		.i_op           (i_op),
		.i_in1          (i_in1),
		.i_in2          (i_in2),
		.i_hold         (i_hold),
		.o_step         (m_step),
		.o_m1_dbl       (m1_dbl),
		.o_m1_sgl       (m1_sgl),
		.o_m2_sel_add   (m2_sel_add),
		.o_m2_sel_max   (m2_sel_max),
		.o_m2_nan       (m2_nan),
		.o_m2_zero_frac (m2_zero_frac),
		.o_m2_sign      (m2_sign),
		.o_m5_fmuld     (m5_fmuld),
		.o_m5_valid     (m5_valid),
		.o_valid        (o_valid)
	);

	fpu_mul_exp_dp u_exp_dp (
		.i_rclk          (i_rclk),
		.i_reset         (i_reset),
		.i_step          (m_step),
		.i_in1_exp       (in1_exp),
		.i_in2_exp       (in2_exp),
		.i_m1_dbl        (m1_dbl),
		.i_m1_sgl        (m1_sgl),
		.i_m2_sel_add    (m2_sel_add),
		.i_m2_sel_max    (m2_sel_max),
		.i_m4_norm_shift (m4_norm_shift),
		.i_m5_round_cout (m5_round_cout),
		.i_m5_fmuld      (m5_fmuld),
		.o_m5_exp_out    (m5_exp_out),
		.o_m5_of         (m5_of),
		.o_m5_uf         (m5_uf)
	);

	// double fraction field also covers the single fraction bits
	fpu_mul_frac_dp u_frac_dp (
		.i_rclk          (i_rclk),
		.i_reset         (i_reset),
		.i_step          (m_step),
		.i_in1_frac      (i_in1.dbl.frac),
		.i_in2_frac      (i_in2.dbl.frac),
		.i_op            (i_op),
		.i_m2_nan        (m2_nan),
		.i_m2_zero_frac  (m2_zero_frac),
		.i_m2_sign       (m2_sign),
		.i_m5_exp_out    (m5_exp_out),
		.i_m5_of         (m5_of),
		.i_m5_uf         (m5_uf),
		.i_m5_valid      (m5_valid),
		.o_m4_norm_shift (m4_norm_shift),
		.o_m5_round_cout (m5_round_cout),
		.o_result        (o_result)
	);

endmodule

`default_nettype wire

// File: verification/tb_fpu_mul.sv
`timescale 1ns/10ps
`default_nettype none
`include "fpu_mul_defines.svh"

module tb_fpu_mul;

	localparam int DLY     = 2;  // drive delay after the rising edge
	localparam int TIMEOUT = 40; // cycles per wait

	logic                      rclk;
	logic                      reset;
	logic                      valid;
	fpu_mul_pkg::fpu_op_e      op;
	fpu_mul_pkg::fpu_operand_u in1;
	fpu_mul_pkg::fpu_operand_u in2;
	logic                      hold;
	wire                       o_valid;
	wire [63:0]                o_result;

	int          errors;
	int          checks;
	logic [31:0] lfsr;
	logic [63:0] exp_q[$];   // expected results, issue order
	int          step_q[$];  // step count at issue
	int          step_cnt;   // step-enabled edges so far
	bit          started;
	bit          was_reset;  // last edge sampled reset
	bit          stepped;    // last edge moved the pipe
	logic        last_valid;
	logic [63:0] last_result;
	logic [63:0] got_exp;
	int          got_step;

	fpu_mul u_dut (
		.i_rclk   (rclk),
		.i_reset  (reset),
		.i_valid  (valid),
		.i_op     (op),
		.i_in1    (in1),
		.i_in2    (in2),
		.i_hold   (hold),
		.o_valid  (o_valid),
		.o_result (o_result)
	);

	always #20 rclk = !rclk; // 40 ns period

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		logic        fb;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[62:0], fb};
		end
		return v;
	endfunction

	// exponent 768..1279, products stay far from both range limits
	function automatic logic [63:0] rand_double();
		logic        s;
		logic [10:0] e;
		logic [51:0] f;
		s = 1'(rand_bits(1));
		e = 11'd768 + 11'(rand_bits(9));
		f = 52'(rand_bits(52));
		return {s, e, f};
	endfunction

	// exponent 96..159, upper half is junk the DUT must ignore
	function automatic logic [63:0] rand_single();
		logic [31:0] up;
		logic        s;
		logic [7:0]  e;
		logic [22:0] f;
		up = 32'(rand_bits(32));
		s  = 1'(rand_bits(1));
		e  = 8'd96 + 8'(rand_bits(6));
		f  = 23'(rand_bits(23));
		return {up, s, e, f};
	endfunction

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// normal single widened to a double, exactly
	function automatic real single_to_real(input logic [31:0] w);
		return $bitstoreal({w[31], 11'(w[30:23]) + 11'd896, w[22:0], 29'd0});
	endfunction

	function automatic logic [63:0] double_product(
		input logic [63:0] a,
		input logic [63:0] b,
		input logic        sign
	);
		logic [63:0] bits;
		bits = $realtobits($bitstoreal(a) * $bitstoreal(b)); // host rounding is rne
		if (bits[62:52] == 11'd0)
			return {sign, 63'd0}; // subnormal or zero, flushed
		else
			return {sign, bits[62:0]}; // overflow already gives inf
	endfunction

	function automatic logic [63:0] single_product(
		input logic [31:0] a,
		input logic [31:0] b,
		input logic        sign
	);
		logic [63:0] bits;
		logic [52:0] sig;
		logic [53:0] sum;
		logic [24:0] rnd;
		int          e;
		bits = $realtobits(single_to_real(a) * single_to_real(b)); // 48-bit product, exact
		e    = int'(bits[62:52]) - 1023 + 127;
		sig  = {1'b1, bits[51:0]};
		// nearest even: add half minus one plus the kept lsb, then truncate
		sum  = {1'b0, sig} + ((54'd1 << 28) - 54'd1) + {53'd0, sig[29]};
		rnd  = sum[53:29];
		if (rnd[24]) begin
			rnd = rnd >> 1;
			e   = e + 1;
		end
		if (e >= `FPU_MUL_SGL_EMAX)
			return {32'd0, sign, 8'hff, 23'd0};
		else if (e <= 0)
			return {32'd0, sign, 31'd0};
		else
			return {32'd0, sign, 8'(e), rnd[22:0]};
	endfunction

	function automatic logic [63:0] expected_product(
		input fpu_mul_pkg::fpu_op_e      o,
		input fpu_mul_pkg::fpu_operand_u a,
		input fpu_mul_pkg::fpu_operand_u b
	);
		logic dbl;
		logic sign;
		int   ea, eb, emax;
		logic fa, fb;   // fraction nonzero
		logic nan, inf, zero;
		dbl = (o == fpu_mul_pkg::OP_FMULD);
		if (dbl) begin
			ea   = int'(a.dbl.exp);
			eb   = int'(b.dbl.exp);
			fa   = |a.dbl.frac;
			fb   = |b.dbl.frac;
			sign = a.dbl.sign ^ b.dbl.sign;
			emax = `FPU_MUL_DBL_EMAX;
		end else begin
			ea   = int'(a.sgl.exp);
			eb   = int'(b.sgl.exp);
			fa   = |a.sgl.frac;
			fb   = |b.sgl.frac;
			sign = a.sgl.sign ^ b.sgl.sign;
			emax = `FPU_MUL_SGL_EMAX;
		end
		zero = (ea == 0) || (eb == 0); // subnormals count as zero
		inf  = (ea == emax) || (eb == emax);
		nan  = (ea == emax && fa) || (eb == emax && fb) || (inf && zero);
		if (nan)
			return dbl ? 64'h7ff8_0000_0000_0000 : 64'h0000_0000_7fc0_0000;
		else if (inf)
			return dbl ? {sign, 11'h7ff, 52'd0} : {32'd0, sign, 8'hff, 23'd0};
		else if (zero)
			return dbl ? {sign, 63'd0} : {32'd0, sign, 31'd0};
		else if (dbl)
			return double_product(a, b, sign);
		else
			return single_product({a.sgl.sign, a.sgl.exp, a.sgl.frac},
			                      {b.sgl.sign, b.sgl.exp, b.sgl.frac}, sign);
	endfunction

	//////////////////////////////////////////////////
	// monitor and scoreboard
	//////////////////////////////////////////////////

	// issue side, same edge the DUT samples
	always @(posedge rclk) begin
		started   = 1'b1;
		was_reset = reset;
		stepped   = !hold && !reset;
		if (reset) begin
			exp_q.delete();  // in-flight ops are dropped
			step_q.delete();
		end else if (!hold) begin
			step_cnt++;
			if (valid) begin
				exp_q.push_back(expected_product(op, in1, in2));
				step_q.push_back(step_cnt);
			end
		end
	end

	// result side, outputs are quiet at the falling edge
	always @(negedge rclk) begin
		if (was_reset) begin
			checks++;
			if (o_valid !== 1'b0 || o_result !== 64'd0) begin
				errors++;
				$display("error at %0t: in reset o_valid=%b o_result=%h",
				         $time, o_valid, o_result);
			end
		end else if (stepped) begin
			if (o_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("a result came out at %0t with no operation in flight", $time);
				end else begin
					got_exp  = exp_q.pop_front();
					got_step = step_q.pop_front();
					checks++;
					if (step_cnt - got_step != `FPU_MUL_DEPTH) begin
						errors++;
						$display("error at %0t: latency %0d steps, expected %0d",
						         $time, step_cnt - got_step, `FPU_MUL_DEPTH);
					end
					if (o_result !== got_exp) begin
						errors++;
						$display("error at %0t: result %h, expected %h",
						         $time, o_result, got_exp);
					end
				end
			end else if (o_valid !== 1'b0) begin
				errors++;
				$display("o_valid is unknown at %0t", $time);
			end else if (step_q.size() != 0 && step_cnt - step_q[0] >= `FPU_MUL_DEPTH) begin
				errors++;
				$display("an operation issued at step %0d never came out", step_q[0]);
				exp_q.delete(0);
				step_q.delete(0);
			end
		end else if (started) begin
			checks++; // held edge
			if (o_valid !== last_valid || o_result !== last_result) begin
				errors++;
				$display("error at %0t: outputs moved under hold, o_valid=%b o_result=%h",
				         $time, o_valid, o_result);
			end
		end
		last_valid  = o_valid;
		last_result = o_result;
	end

	//////////////////////////////////////////////////
	// driver tasks
	//////////////////////////////////////////////////

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge rclk);
			#DLY;
		end
	endtask

	// one op on the next edge
	task automatic issue_op(
		input fpu_mul_pkg::fpu_op_e o,
		input logic [63:0]          a,
		input logic [63:0]          b
	);
		valid = 1'b1;
		op    = o;
		in1   = a;
		in2   = b;
		@(posedge rclk);
		#DLY;
		valid = 1'b0;
	endtask

	task automatic end_run();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	endtask

	task automatic wait_for_results();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < TIMEOUT) begin
			@(posedge rclk);
			#DLY;
			n++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("timeout, %0d results still missing after %0d cycles",
			         exp_q.size(), TIMEOUT);
			end_run();
		end
	endtask

	// single op against a hand-derived word, on top of the model check
	task automatic check_one(
		input fpu_mul_pkg::fpu_op_e o,
		input logic [63:0]          a,
		input logic [63:0]          b,
		input logic [63:0]          want,
		input string                what
	);
		issue_op(o, a, b);
		wait_for_results();
		checks++;
		if (o_result !== want) begin
			errors++;
			$display("error at %0t: %s gave %h, expected %h", $time, what, o_result, want);
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic idle_after_reset();
		idle_cycles(8); // monitor flags any output
	endtask

	task automatic normal_products();
		logic [63:0] a;
		logic [63:0] b;
		int          i;
		check_one(fpu_mul_pkg::OP_FMULS, 64'h3fc0_0000, 64'h3fc0_0000,
		          64'h4010_0000, "single 1.5 * 1.5"); // needs normalize shift
		check_one(fpu_mul_pkg::OP_FMULD, 64'h3ff8_0000_0000_0000, 64'hbff8_0000_0000_0000,
		          64'hc002_0000_0000_0000, "double 1.5 * -1.5");
		for (i = 0; i < 20; i++) begin
			a = rand_double();
			b = rand_double();
			issue_op(fpu_mul_pkg::OP_FMULD, a, b);
		end
		for (i = 0; i < 20; i++) begin
			a = rand_single();
			b = rand_single();
			issue_op(fpu_mul_pkg::OP_FMULS, a, b);
		end
		wait_for_results();
	endtask

	// significand products of exactly 2 - 2^-24 and 2 - 2^-53, ties round up
	task automatic round_carry();
		check_one(fpu_mul_pkg::OP_FMULS, 64'h3f91_8e00, 64'h3fe1_2000,
		          64'h4000_0000, "single rounding carry");
		check_one(fpu_mul_pkg::OP_FMULD, 64'h3fff_ffff_fc00_0000, 64'h3ff0_0000_0200_0000,
		          64'h4000_0000_0000_0000, "double rounding carry");
		check_one(fpu_mul_pkg::OP_FMULD, 64'hbfff_ffff_fc00_0000, 64'h3ff0_0000_0200_0000,
		          64'hc000_0000_0000_0000, "negative double rounding carry");
	endtask

	task automatic range_limits();
		check_one(fpu_mul_pkg::OP_FMULD, {1'b0, 11'd2000, 52'h1_2345_6789_abcd},
		          {1'b1, 11'd1100, 52'h8_0000_0000_0001}, 64'hfff0_0000_0000_0000,
		          "double overflow");
		check_one(fpu_mul_pkg::OP_FMULS, 64'h6400_0000, 64'h6400_0000,
		          64'h7f80_0000, "single overflow");
		check_one(fpu_mul_pkg::OP_FMULD, {1'b1, 11'd100, 52'h4_4444_0000_0001},
		          {1'b0, 11'd100, 52'h0_0000_0000_0007}, 64'h8000_0000_0000_0000,
		          "double underflow");
		check_one(fpu_mul_pkg::OP_FMULS, 64'h0a00_0000, 64'h8f00_0000,
		          64'h8000_0000, "single underflow");
	endtask

	task automatic special_operands();
		check_one(fpu_mul_pkg::OP_FMULD, 64'h7ff0_0000_0000_0001, 64'h3ff8_0000_0000_0000,
		          64'h7ff8_0000_0000_0000, "double nan input");
		check_one(fpu_mul_pkg::OP_FMULS, 64'hffa0_0000, 64'h3fc0_0000,
		          64'h7fc0_0000, "single nan input");
		check_one(fpu_mul_pkg::OP_FMULD, 64'hfff0_0000_0000_0000, 64'h0,
		          64'h7ff8_0000_0000_0000, "double inf * 0");
		check_one(fpu_mul_pkg::OP_FMULS, 64'h0, 64'h7f80_0000,
		          64'h7fc0_0000, "single 0 * inf");
		check_one(fpu_mul_pkg::OP_FMULD, 64'h7ff0_0000_0000_0000, 64'hc000_0000_0000_0000,
		          64'hfff0_0000_0000_0000, "double inf * -2");
		check_one(fpu_mul_pkg::OP_FMULS, 64'hff80_0000, 64'h4040_0000,
		          64'hff80_0000, "single -inf * 3");
		check_one(fpu_mul_pkg::OP_FMULD, 64'h8000_0000_0000_0000, 64'h4000_0000_0000_0000,
		          64'h8000_0000_0000_0000, "double -0 * 2");
		check_one(fpu_mul_pkg::OP_FMULS, 64'h8000_0123, 64'h4040_0000,
		          64'h8000_0000, "single subnormal * 3");
		check_one(fpu_mul_pkg::OP_FMULD, 64'h0000_0000_0000_0001, 64'hc010_0000_0000_0000,
		          64'h8000_0000_0000_0000, "double subnormal * -4");
	endtask

	task automatic latency_and_hold();
		logic [63:0] a;
		logic [63:0] b;
		int          i;
		a = rand_double();
		b = rand_double();
		issue_op(fpu_mul_pkg::OP_FMULD, a, b); // lone op, monitor checks 5 steps
		wait_for_results();
		for (i = 0; i < 6; i++) begin
			a = rand_single();
			b = rand_single();
			issue_op(fpu_mul_pkg::OP_FMULS, a, b);
		end
		// freeze with results on the output and a new op waiting
		a     = rand_double();
		b     = rand_double();
		hold  = 1'b1;
		valid = 1'b1;
		op    = fpu_mul_pkg::OP_FMULD;
		in1   = a;
		in2   = b;
		idle_cycles(3);
		hold = 1'b0;
		idle_cycles(1); // op taken here, once
		valid = 1'b0;
		wait_for_results();
	endtask

	task automatic reset_in_flight();
		logic [63:0] a;
		logic [63:0] b;
		int          i;
		for (i = 0; i < 3; i++) begin
			a = rand_double();
			b = rand_double();
			issue_op(fpu_mul_pkg::OP_FMULD, a, b);
		end
		reset = 1'b1;
		idle_cycles(3);
		reset = 1'b0;
		idle_cycles(8); // flushed ops must not come out
	endtask

	initial begin
		rclk     = 1'b0;
		reset    = 1'b1;
		valid    = 1'b0;
		op       = fpu_mul_pkg::OP_FMULD;
		in1      = '0;
		in2      = '0;
		hold     = 1'b0;
		lfsr     = 32'h48dc_f4b8;
		errors   = 0;
		checks   = 0;
		step_cnt = 0;
		repeat (3) @(posedge rclk);
		#DLY;
		reset = 1'b0;
		idle_after_reset();
		normal_products();
		round_carry();
		range_limits();
		special_operands();
		latency_and_hold();
		reset_in_flight();
		end_run();
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
design/fpu_mul_pkg.sv
design/fpu_mul_ctl.sv
design/fpu_mul_exp_dp.sv
design/fpu_mul_frac_dp.sv
design/fpu_mul.sv
verification/tb_fpu_mul.sv

// File: Bender.yml
package:
  name: fpu_mul

export_include_dirs:
  - include

sources:
  - files:
      - design/fpu_mul_pkg.sv
      - design/fpu_mul_ctl.sv
      - design/fpu_mul_exp_dp.sv
      - design/fpu_mul_frac_dp.sv
      - design/fpu_mul.sv
  - target: test
    files:
      - verification/tb_fpu_mul.sv
